// ==== hdl/arp_pkg.sv ====
package arp_pkg;

  // -------------------------------------------------------------------------
  // Field types
  // -------------------------------------------------------------------------
  typedef logic [47:0] mac_t;                        // Hardware address, first byte in [47:40]
  typedef logic [31:0] ipv4_t;                       // Protocol address, first byte in [31:24]
  typedef logic [7:0]  byte_t;                       // One stream byte
  typedef logic [5:0]  pos_t;                        // Byte offset within a frame

  typedef struct packed
  {
    logic  valid;                                    // Byte present, no back-pressure
    logic  last;                                     // Final byte of the frame
    byte_t data;
  } rx_byte_t;

  typedef struct packed
  {
    logic  valid;                                    // Held until acknowledged
    logic  last;                                     // Final byte of the reply
    byte_t data;
  } tx_byte_t;

  // -------------------------------------------------------------------------
  // Frame constants
  // -------------------------------------------------------------------------
  localparam int          FRAME_BYTES   = 42;        // ARP frame without padding or CRC
  localparam logic [15:0] ETHERTYPE_ARP = 16'h0806;
  localparam logic [15:0] HWTYPE_ETH    = 16'h0001;
  localparam logic [15:0] PTYPE_IPV4    = 16'h0800;
  localparam byte_t       HLEN          = 8'd6;      // Bytes per hardware address
  localparam byte_t       PLEN          = 8'd4;      // Bytes per protocol address
  localparam logic [15:0] OP_REQUEST    = 16'd1;
  localparam logic [15:0] OP_REPLY      = 16'd2;
  localparam mac_t        MAC_BCAST     = '1;

  // Field start offsets, Ethernet header then ARP body
  localparam pos_t OFS_DMAC  = 6'd0;
  localparam pos_t OFS_SMAC  = 6'd6;
  localparam pos_t OFS_TYPE  = 6'd12;
  localparam pos_t OFS_HTYPE = 6'd14;
  localparam pos_t OFS_PTYPE = 6'd16;
  localparam pos_t OFS_HLEN  = 6'd18;
  localparam pos_t OFS_PLEN  = 6'd19;
  localparam pos_t OFS_OPER  = 6'd20;
  localparam pos_t OFS_SHA   = 6'd22;
  localparam pos_t OFS_SPA   = 6'd28;
  localparam pos_t OFS_THA   = 6'd32;
  localparam pos_t OFS_TPA   = 6'd38;

  // Output FIFO sizing
  localparam int FIFO_DEPTH = 64;
  localparam int FIFO_CNT_W = 7;                     // Holds 0..FIFO_DEPTH

endpackage

// ==== hdl/arp_byte_counter.sv ====
`timescale 1ns/1ps

module arp_byte_counter
(
  input  logic          clk_tx,
  input  logic          rst_txn,
  input  logic          clear,                       // Restart at offset 0
  input  logic          inc,                         // One byte consumed or emitted
  output arp_pkg::pos_t pos
);

  import arp_pkg::*;

  // Stops at FRAME_BYTES so padding never wraps the offset
  always_ff @(posedge clk_tx or negedge rst_txn)
  begin
    if (!rst_txn)
    begin
      pos <= '0;
    end
    else if (clear)
    begin
      pos <= '0;                                     // Clear wins over inc
    end
    else if (inc && (pos != pos_t'(FRAME_BYTES)))
    begin
      pos <= pos + 1'b1;
    end
  end

endmodule

// ==== hdl/arp_rx_fsm.sv ====
`timescale 1ns/1ps

module arp_rx_fsm
(
  input  logic              clk_tx,
  input  logic              rst_txn,
  input  arp_pkg::rx_byte_t rx,
  input  arp_pkg::ipv4_t    my_ipv4,
  output logic              accept,                  // One cycle after the last byte
  output arp_pkg::mac_t     sender_mac,
  output arp_pkg::ipv4_t    sender_ip
);

  import arp_pkg::*;

  typedef enum logic [3:0]
  {
    IDLE,
    DMAC,
    SMAC,
    TYPES,
    PROTO,
    SHA,
    SPA,
    THA,
    TPA,
    DROP,
    DONE
  } rx_state_t;

  rx_state_t   state;
  rx_state_t   adv;                                  // State after this byte, last ignored
  pos_t        pos;                                  // Offset of the byte on rx
  logic [39:0] shreg;                                // Previous five bytes
  logic [47:0] fld;                                  // Field ending with the current byte

  // Unicast station address, nonzero with the group bit clear
  function automatic logic station_ok(mac_t m);
    return (m != '0) && !m[40];
  endfunction

  arp_byte_counter u_rx_cnt
  (
    .clk_tx  (clk_tx),
    .rst_txn (rst_txn),
    .clear   (rx.valid && rx.last),                  // Next frame starts at offset 0
    .inc     (rx.valid),
    .pos     (pos)
  );

  assign fld = {shreg, rx.data};

  // -------------------------------------------------------------------------
  // Field walk, each field checked on its final byte
  // -------------------------------------------------------------------------
  always_comb
  begin
    adv = state;
    unique case (state)
      IDLE  : adv = DMAC;                            // Byte 0 is the first DMAC byte
      DMAC  : if (pos == OFS_SMAC - 1)
                adv = (fld == MAC_BCAST) ? SMAC : DROP;
      SMAC  : if (pos == OFS_TYPE - 1)
                adv = station_ok(fld) ? TYPES : DROP;
      TYPES : if (pos == OFS_PTYPE - 1)             // EtherType and HTYPE together
                adv = (fld[31:16] == ETHERTYPE_ARP && fld[15:0] == HWTYPE_ETH) ? PROTO : DROP;
      PROTO : if (pos == OFS_SHA - 1)               // PTYPE, HLEN, PLEN and OPER
                adv = (fld[47:32] == PTYPE_IPV4 && fld[31:24] == HLEN &&
                       fld[23:16] == PLEN && fld[15:0] == OP_REQUEST) ? SHA : DROP;
      SHA   : if (pos == OFS_SPA - 1)
                adv = station_ok(fld) ? SPA : DROP;
      SPA   : if (pos == OFS_THA - 1)               // Neither zero nor broadcast IP
                adv = (fld[31:0] != '0 && fld[31:0] != '1) ? THA : DROP;
      THA   : if (pos == OFS_TPA - 1)
                adv = (fld == '0) ? TPA : DROP;
      TPA   : if (pos == FRAME_BYTES - 1)
                adv = (fld[31:0] == my_ipv4) ? DONE : DROP;
      DROP  : adv = DROP;                            // Wait out the frame
      DONE  : adv = DONE;                            // Padding bytes ignored
      default : adv = DROP;
    endcase
  end

  always_ff @(posedge clk_tx or negedge rst_txn)
  begin
    if (!rst_txn)
    begin
      state  <= IDLE;
      accept <= 1'b0;
    end
    else
    begin
      // A short frame ends before DONE and is not accepted
      accept <= rx.valid && rx.last && (adv == DONE);
      if (rx.valid)
        state <= rx.last ? IDLE : adv;
    end
  end

  // Shift path and captured sender fields
  always_ff @(posedge clk_tx)
  begin
    if (rx.valid)
    begin
      shreg <= fld[39:0];
      if (state == SHA && pos == OFS_SPA - 1)
        sender_mac <= fld;
      if (state == SPA && pos == OFS_THA - 1)
        sender_ip <= fld[31:0];
    end
  end

endmodule

// ==== hdl/arp_cache.sv ====
`timescale 1ns/1ps

module arp_cache
(
  input  logic           clk_tx,
  input  logic           rst_txn,
  input  logic           accept,                     // Request accepted this cycle
  input  arp_pkg::mac_t  sender_mac,
  input  arp_pkg::ipv4_t sender_ip,
  output arp_pkg::mac_t  cache_mac,
  output arp_pkg::ipv4_t cache_ip,
  output logic           poison                      // Same IP seen with another MAC
);

  import arp_pkg::*;

  typedef struct packed
  {
    logic  poison;
    ipv4_t ip;
    mac_t  mac;
  } entry_t;

  entry_t entry;

  // Single entry, always replaced by the newest request
  always_ff @(posedge clk_tx or negedge rst_txn)
  begin
    if (!rst_txn)
    begin
      entry <= '0;
    end
    else if (accept)
    begin
      entry.poison <= (entry.ip == sender_ip) && (entry.mac != sender_mac);
      entry.ip     <= sender_ip;
      entry.mac    <= sender_mac;
    end
  end

  assign cache_mac = entry.mac;
  assign cache_ip  = entry.ip;
  assign poison    = entry.poison;

endmodule

// ==== hdl/arp_reply_tx.sv ====
`timescale 1ns/1ps

module arp_reply_tx
(
  input  logic                                clk_tx,
  input  logic                                rst_txn,
  input  logic                                accept,
  input  logic [arp_pkg::FIFO_CNT_W-1:0]      free,          // Empty FIFO entries
  input  arp_pkg::mac_t                       cache_mac,
  input  arp_pkg::ipv4_t                      cache_ip,
  input  arp_pkg::mac_t                       my_mac,
  input  arp_pkg::ipv4_t                      my_ipv4,
  output logic                                push,
  output logic [$bits(arp_pkg::byte_t):0]     push_byte      // {last, data}
);

  import arp_pkg::*;

  typedef enum logic [1:0]
  {
    IDLE,
    ARM,                                             // Cache entry settles
    SEND
  } reply_state_t;

  reply_state_t state;
  pos_t         pos;                                 // Reply byte being emitted
  byte_t        data;

  // Byte i of an n-byte big-endian field
  function automatic byte_t pick(logic [47:0] v, int unsigned n, pos_t i);
    return v[8 * (n - 1 - i) +: 8];
  endfunction

  arp_byte_counter u_tx_cnt
  (
    .clk_tx  (clk_tx),
    .rst_txn (rst_txn),
    .clear   (state != SEND),
    .inc     (state == SEND),
    .pos     (pos)
  );

  // A reply needs room for the whole frame or it is not started
  always_ff @(posedge clk_tx or negedge rst_txn)
  begin
    if (!rst_txn)
      state <= IDLE;
    else
    begin
      unique case (state)
        IDLE    : if (accept && free >= FRAME_BYTES) state <= ARM;
        ARM     : state <= SEND;
        SEND    : if (pos == FRAME_BYTES - 1) state <= IDLE;
        default : state <= IDLE;
      endcase
    end
  end

  // -------------------------------------------------------------------------
  // Reply byte select
  // -------------------------------------------------------------------------
  always_comb
  begin
    if (pos < OFS_SMAC)       data = pick(cache_mac, 6, pos - OFS_DMAC);      // Back to requester
    else if (pos < OFS_TYPE)  data = pick(my_mac, 6, pos - OFS_SMAC);
    else if (pos < OFS_HTYPE) data = pick(48'(ETHERTYPE_ARP), 2, pos - OFS_TYPE);
    else if (pos < OFS_PTYPE) data = pick(48'(HWTYPE_ETH), 2, pos - OFS_HTYPE);
    else if (pos < OFS_HLEN)  data = pick(48'(PTYPE_IPV4), 2, pos - OFS_PTYPE);
    else if (pos < OFS_PLEN)  data = HLEN;
    else if (pos < OFS_OPER)  data = PLEN;
    else if (pos < OFS_SHA)   data = pick(48'(OP_REPLY), 2, pos - OFS_OPER);
    else if (pos < OFS_SPA)   data = pick(my_mac, 6, pos - OFS_SHA);
    else if (pos < OFS_THA)   data = pick(48'(my_ipv4), 4, pos - OFS_SPA);
    else if (pos < OFS_TPA)   data = pick(cache_mac, 6, pos - OFS_THA);
    else                      data = pick(48'(cache_ip), 4, pos - OFS_TPA);
  end

  assign push      = (state == SEND);
  assign push_byte = {pos == FRAME_BYTES - 1, data}; // Last flag rides on byte 41

endmodule

// ==== hdl/arp_tx_fifo.sv ====
`timescale 1ns/1ps

module arp_tx_fifo
(
  input  logic                               clk_tx,
  input  logic                               rst_txn,
  input  logic                               push,
  input  logic [$bits(arp_pkg::byte_t):0]    push_byte,      // {last, data}
  output arp_pkg::tx_byte_t                  tx,
  input  logic                               tx_ack,
  output logic [arp_pkg::FIFO_CNT_W-1:0]     free
);

  import arp_pkg::*;

  logic [$bits(byte_t):0]  mem [FIFO_DEPTH];         // Byte plus last flag
  logic [FIFO_CNT_W-2:0]   wr_ptr;
  logic [FIFO_CNT_W-2:0]   rd_ptr;
  logic [FIFO_CNT_W-1:0]   count;                    // Occupied entries
  logic                    wr;
  logic                    rd;

  assign wr = push && (count != FIFO_CNT_W'(FIFO_DEPTH));    // Overflow guard
  assign rd = tx.valid && tx_ack;                    // Transfer cycle

  // -------------------------------------------------------------------------
  // Pointers and fill level
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_tx or negedge rst_txn)
  begin
    if (!rst_txn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr)
        wr_ptr <= wr_ptr + 1'b1;                     // Wraps at FIFO_DEPTH
      if (rd)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + FIFO_CNT_W'(wr) - FIFO_CNT_W'(rd);
    end
  end

  always_ff @(posedge clk_tx)
  begin
    if (wr)
      mem[wr_ptr] <= push_byte;
  end

  // Head entry stays put until popped, so tx holds while not acked
  always_comb
  begin
    tx.valid = (count != '0);
    tx.last  = mem[rd_ptr][$bits(byte_t)];
    tx.data  = mem[rd_ptr][$bits(byte_t)-1:0];
  end

  assign free = FIFO_CNT_W'(FIFO_DEPTH) - count;

endmodule

// ==== hdl/arp_responder.sv ====
`timescale 1ns/1ps

module arp_responder
(
  input  logic              clk_tx,
  input  logic              rst_txn,
  input  arp_pkg::mac_t     my_mac,                  // Local station address
  input  arp_pkg::ipv4_t    my_ipv4,
  input  arp_pkg::rx_byte_t rx,                      // Received frame bytes, no CRC
  output arp_pkg::tx_byte_t tx,                      // Reply bytes toward the MAC
  input  logic              tx_ack,
  output arp_pkg::mac_t     cache_mac,
  output arp_pkg::ipv4_t    cache_ip,
  output logic              poison
);

  import arp_pkg::*;

  logic                   accept;
  mac_t                   sender_mac;
  ipv4_t                  sender_ip;
  logic [FIFO_CNT_W-1:0]  free;
  logic                   push;
  logic [$bits(byte_t):0] push_byte;                 // {last, data}

  // -------------------------------------------------------------------------
  // Receive parse, cache, reply build, output buffer
  // -------------------------------------------------------------------------
  arp_rx_fsm u_rx_fsm
  (
    .clk_tx, .rst_txn, .rx, .my_ipv4,
    .accept, .sender_mac, .sender_ip
  );

  arp_cache u_cache
  (
    .clk_tx, .rst_txn, .accept, .sender_mac, .sender_ip,
    .cache_mac, .cache_ip, .poison
  );

  arp_reply_tx u_reply_tx
  (
    .clk_tx, .rst_txn, .accept, .free, .cache_mac, .cache_ip,
    .my_mac, .my_ipv4, .push, .push_byte
  );

  arp_tx_fifo u_tx_fifo
  (
    .clk_tx, .rst_txn, .push, .push_byte,
    .tx, .tx_ack, .free
  );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock
(
  output logic clk_tx,
  output logic rst_txn
);

  initial
  begin
    clk_tx = 1'b0;
    forever #2 clk_tx = ~clk_tx;                     // 4 ns period
  end

  initial
  begin
    rst_txn = 1'b0;
    repeat (16) @(posedge clk_tx);                   // 16 cycles in reset
    @(negedge clk_tx);
    rst_txn = 1'b1;                                  // Release away from the active edge
  end

endmodule

// ==== test/arp_responder_assert.sv ====
`timescale 1ns/1ps

module arp_responder_assert
(
  input logic              clk_tx,
  input logic              rst_txn,
  input arp_pkg::tx_byte_t tx,
  input logic              tx_ack
);

  // No reply byte offered while reset is applied
  reset_quiet: assert property (@(posedge clk_tx) !rst_txn |-> !tx.valid)
    else $error("tx.valid high during reset");

  // Offered byte holds until taken
  hold_stable: assert property (@(posedge clk_tx) disable iff (!rst_txn)
    tx.valid && !tx_ack |=> $stable(tx))
    else $error("tx changed while waiting for tx_ack");

  hold_valid: assert property (@(posedge clk_tx) disable iff (!rst_txn)
    tx.valid && !tx_ack |=> tx.valid)
    else $error("tx.valid dropped before tx_ack");

endmodule

bind arp_responder arp_responder_assert u_tx_assert
(
  .clk_tx  (clk_tx),
  .rst_txn (rst_txn),
  .tx      (tx),
  .tx_ack  (tx_ack)
);

// ==== test/arp_responder_tb.sv ====
`timescale 1ns/1ps

module arp_responder_tb;

  import arp_pkg::*;

  localparam mac_t  MY_MAC  = 48'h02_11_22_33_44_55;
  localparam ipv4_t MY_IP   = 32'hc0_a8_01_0a;       // 192.168.1.10
  localparam int    TIMEOUT = 1000;                  // Cycles without progress
  localparam mac_t  MAC_A   = 48'h02_00_00_00_00_0a;
  localparam mac_t  MAC_B   = 48'h02_00_00_00_00_0b;
  localparam mac_t  MAC_C   = 48'h02_00_00_00_00_0c;
  localparam mac_t  MAC_E   = 48'h02_00_00_00_00_0e;
  localparam mac_t  MAC_F   = 48'h02_00_00_00_00_0f;
  localparam ipv4_t IP_A    = 32'h0a_00_00_01;
  localparam ipv4_t IP_B    = 32'h0a_00_00_02;
  localparam ipv4_t IP_D    = 32'h0a_00_00_04;
  localparam ipv4_t IP_E    = 32'h0a_00_00_05;
  localparam ipv4_t IP_F    = 32'h0a_00_00_06;

  // One corrupted field per acceptance rule
  localparam int C_NONE  = 0;
  localparam int C_DMAC  = 1;
  localparam int C_GROUP = 2;
  localparam int C_TYPE  = 3;
  localparam int C_OPER  = 4;
  localparam int C_SIP0  = 5;
  localparam int C_THA   = 6;
  localparam int C_TPA   = 7;
  localparam int C_SHORT = 8;

  logic        clk_tx;
  logic        rst_txn;
  rx_byte_t    rx;
  tx_byte_t    tx;
  logic        tx_ack;
  mac_t        cache_mac;
  ipv4_t       cache_ip;
  logic        poison;
  logic [31:0] rng;                                  // xorshift state
  logic        stall_en;                             // Random ack stalls
  byte_t       build_q [$];                          // Scratch for frame builders
  byte_t       frame_a [$];
  byte_t       frame_b [$];

  tb_clock u_clock (.clk_tx(clk_tx), .rst_txn(rst_txn));

  arp_responder arp_responder_i
  (
    .clk_tx    (clk_tx),
    .rst_txn   (rst_txn),
    .my_mac    (MY_MAC),
    .my_ipv4   (MY_IP),
    .rx        (rx),
    .tx        (tx),
    .tx_ack    (tx_ack),
    .cache_mac (cache_mac),
    .cache_ip  (cache_ip),
    .poison    (poison)
  );

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  // -------------------------------------------------------------------------
  // Compare tasks
  // -------------------------------------------------------------------------
  task automatic check_byte(string name, byte_t got, byte_t exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_mac(string name, mac_t got, mac_t exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_ip(string name, ipv4_t got, ipv4_t exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  // -------------------------------------------------------------------------
  // Frame builders with big-endian fields
  // -------------------------------------------------------------------------
  task automatic add_field(logic [47:0] v, int n);
    for (int i = n - 1; i >= 0; i--)
      build_q.push_back(v[8 * i +: 8]);
  endtask

  task automatic build_request(mac_t smac, ipv4_t sip, int corrupt, int len);
    mac_t sha;
    sha = (corrupt == C_GROUP) ? (smac | 48'h01_00_00_00_00_00) : smac;  // Group bit 40
    build_q = {};
    add_field((corrupt == C_DMAC) ? 48'h02_00_00_00_00_99 : 48'hffff_ffff_ffff, 6);
    add_field(sha, 6);
    add_field((corrupt == C_TYPE) ? 48'h0800 : 48'h0806, 2);
    add_field(48'h0001_0800, 4);                     // HTYPE and PTYPE
    add_field(48'h0604, 2);                          // HLEN and PLEN
    add_field((corrupt == C_OPER) ? 48'h0002 : 48'h0001, 2);
    add_field(sha, 6);
    add_field((corrupt == C_SIP0) ? 48'h0 : 48'(sip), 4);
    add_field((corrupt == C_THA) ? 48'h1 : 48'h0, 6);
    add_field((corrupt == C_TPA) ? 48'(MY_IP + 1) : 48'(MY_IP), 4);
    while (build_q.size() < len)
      build_q.push_back(8'h00);                      // Padding
    while (build_q.size() > len)
      void'(build_q.pop_back());                     // Truncated frame
  endtask

  task automatic build_reply(mac_t dmac, ipv4_t dip);
    build_q = {};
    add_field(dmac, 6);
    add_field(MY_MAC, 6);
    add_field(48'h0806_0001_0800, 6);                // EtherType, HTYPE, PTYPE
    add_field(48'h0604_0002, 4);                     // Lengths and reply opcode
    add_field(MY_MAC, 6);
    add_field(48'(MY_IP), 4);
    add_field(dmac, 6);
    add_field(48'(dip), 4);
  endtask

  // -------------------------------------------------------------------------
  // Stream drivers and reply collector
  // -------------------------------------------------------------------------
  task automatic send_frame(input byte_t f [$]);
    foreach (f[i])
    begin
      @(negedge clk_tx);
      rx = {1'b1, i == f.size() - 1, f[i]};
    end
    @(negedge clk_tx);
    rx = '0;
    repeat (7) @(negedge clk_tx);                    // Inter-frame gap
  endtask

  task automatic collect_reply(mac_t dmac, ipv4_t dip);
    byte_t exp [$];
    int    n;
    int    idle;
    logic  ack;
    build_reply(dmac, dip);
    exp  = build_q;
    n    = 0;
    idle = 0;
    while (n < FRAME_BYTES)
    begin
      @(negedge clk_tx);
      rng    = xorshift(rng);
      ack    = !stall_en || (rng[1:0] != 2'b00);     // Stall about one cycle in four
      tx_ack = ack;
      if (tx.valid && ack)
      begin
        check_byte($sformatf("tx.data[%0d]", n), tx.data, exp[n]);
        check_flag($sformatf("tx.last[%0d]", n), tx.last, n == FRAME_BYTES - 1);
        n++;
        idle = 0;
      end
      else if (idle++ == TIMEOUT)
        report_failure("reply byte did not arrive before the timeout");
    end
    @(negedge clk_tx);
    tx_ack = 1'b0;
  endtask

  task automatic expect_silence(int cycles);
    repeat (cycles)
    begin
      @(negedge clk_tx);
      if (tx.valid)
        report_failure("tx.valid rose although no reply was due");
    end
  endtask

  task automatic request_and_reply(mac_t smac, ipv4_t sip, int len);
    build_request(smac, sip, C_NONE, len);
    send_frame(build_q);
    collect_reply(smac, sip);
    expect_silence(50);                              // Exactly one reply
    check_mac("cache_mac", cache_mac, smac);
    check_ip("cache_ip", cache_ip, sip);
  endtask

  // -------------------------------------------------------------------------
  // Directed tests
  // -------------------------------------------------------------------------
  task automatic test_valid_request();
    request_and_reply(MAC_A, IP_A, FRAME_BYTES);
    check_flag("poison", poison, 1'b0);
  endtask

  task automatic test_rejected_frames();
    for (int c = C_DMAC; c <= C_SHORT; c++)
    begin
      build_request(MAC_E, IP_E, c, (c == C_SHORT) ? FRAME_BYTES - 1 : FRAME_BYTES);
      send_frame(build_q);
      expect_silence(200);
      check_mac("cache_mac", cache_mac, MAC_A);      // Entry from the valid request
      check_ip("cache_ip", cache_ip, IP_A);
    end
  endtask

  task automatic test_padding();
    request_and_reply(MAC_B, IP_B, 60);
    check_flag("poison", poison, 1'b0);
  endtask

  task automatic test_poison();
    request_and_reply(MAC_C, IP_B, FRAME_BYTES);     // Same IP with a new MAC
    check_flag("poison", poison, 1'b1);
    request_and_reply(MAC_C, IP_D, FRAME_BYTES);
    check_flag("poison", poison, 1'b0);
  endtask

  task automatic test_backpressure();
    stall_en = 1'b1;
    build_request(MAC_E, IP_E, C_NONE, FRAME_BYTES);
    frame_a = build_q;
    build_request(MAC_F, IP_F, C_NONE, FRAME_BYTES);
    frame_b = build_q;
    fork
      begin
        send_frame(frame_a);
        send_frame(frame_b);
      end
      begin
        collect_reply(MAC_E, IP_E);                  // First reply drains under stalls
        collect_reply(MAC_F, IP_F);
      end
    join
    expect_silence(50);
    check_mac("cache_mac", cache_mac, MAC_F);
    check_ip("cache_ip", cache_ip, IP_F);
    stall_en = 1'b0;
  endtask

  initial
  begin
    int waited;
    rx       = '0;
    tx_ack   = 1'b0;
    stall_en = 1'b0;
    rng      = 32'h01f9925a;
    waited   = 0;
    while (rst_txn !== 1'b1)
    begin
      @(negedge clk_tx);
      if (waited++ == 100)
        report_failure("reset was never released");
    end
    test_valid_request();
    test_rejected_frames();
    test_padding();
    test_poison();
    test_backpressure();
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== sources.f ====
hdl/arp_pkg.sv
hdl/arp_byte_counter.sv
hdl/arp_rx_fsm.sv
hdl/arp_cache.sv
hdl/arp_reply_tx.sv
hdl/arp_tx_fifo.sv
hdl/arp_responder.sv
test/tb_clock.sv
test/arp_responder_assert.sv
test/arp_responder_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= arp_responder_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FILELIST  ?= sources.f

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
